//--- hw/periph_defines.svh
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// ********************
// Bus geometry
// ********************
`define WB_AW 12
`define WB_DW 32

// Slave select and register fields of the byte address
`define SLV_MSB 11
`define SLV_LSB 8
`define REG_MSB 4
`define REG_LSB 2

// Register offsets, in words
`define REG_IN       0
`define REG_OUT      1
`define REG_OE       2
`define REG_IRQ_EN   3
`define REG_IRQ_STAT 4

// ********************
// Board and robot I/O widths
// ********************
`define GPIO_W     32
`define BTN_W      5
`define SW_W       16
`define BOT_CTRL_W 8
`define BOT_STAT_W 2

// Switch that sets the robot configuration
`define SW_CFG_BIT 15

// Stable cycles before a debounced level changes
`define DB_CYCLES 16

`endif

//--- hw/wb_pkg.sv
`include "periph_defines.svh"

package wb_pkg;

   // Bus address and data words
   typedef logic [`WB_AW-1:0] wb_addr_t;
   typedef logic [`WB_DW-1:0] wb_data_t;

   // Slave index from the select field
   typedef enum logic [3:0] {
      SLV_GPIO     = 4'd0,
      SLV_BTN      = 4'd1,
      SLV_BOT      = 4'd2,
      SLV_BOT_STAT = 4'd3,
      SLV_NONE     = 4'hf
   } wb_slave_e;

   // Register index inside one GPIO block
   typedef enum logic [2:0] {
      RS_IN       = 3'(`REG_IN),
      RS_OUT      = 3'(`REG_OUT),
      RS_OE       = 3'(`REG_OE),
      RS_IRQ_EN   = 3'(`REG_IRQ_EN),
      RS_IRQ_STAT = 3'(`REG_IRQ_STAT)
   } reg_sel_e;

endpackage

//--- hw/io_pkg.sv
`include "periph_defines.svh"

package io_pkg;

   // Pushbuttons, up is bit 0
   typedef struct packed {
      logic centre;
      logic right;
      logic left;
      logic down;
      logic up;
   } btn_t;

   // Slide switches share the low GPIO pads
   typedef logic [`SW_W-1:0] sw_t;

   // Robot motor control and information word
   typedef logic [`BOT_CTRL_W-1:0] bot_ctrl_t;
   typedef logic [`GPIO_W-1:0]     bot_info_t;

   // Robot status, update sync in bit 0
   typedef struct packed {
      logic cfg_sw;
      logic updt_sync;
   } bot_stat_t;

endpackage

//--- hw/wb_if.sv
interface wb_if
   import wb_pkg::*;
();

   // Request side
   wb_addr_t adr;
   wb_data_t dat_w;
   logic     we;
   logic     cyc;
   logic     stb;

   // Response side
   wb_data_t dat_r;
   logic     ack;

   modport master (
      output adr,
      output dat_w,
      output we,
      output cyc,
      output stb,
      input  dat_r,
      input  ack
   );

   modport slave (
      input  adr,
      input  dat_w,
      input  we,
      input  cyc,
      input  stb,
      output dat_r,
      output ack
   );

endinterface

//--- hw/debounce_filter.sv
`include "periph_defines.svh"

module debounce_filter #(
   parameter type T      = logic,
   parameter int  CYCLES = `DB_CYCLES
) (
   input  logic clk,
   input  logic i_arst_n,
   input  T     i_raw,
   output T     o_clean
);

   localparam int           CW      = $clog2(CYCLES + 1);
   localparam logic [CW-1:0] CNT_MAX = CW'(CYCLES);
   localparam logic [CW-1:0] LOAD_AT = CW'(CYCLES - 1);

   T              meta_q;
   T              sync_q;
   T              last_q;
   logic [CW-1:0] cnt;
   logic          stable;

   // Same sample as one cycle ago
   assign stable = (sync_q == last_q);

   // ********************
   // Synchronizer and stability counter
   // ********************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         meta_q  <= '0;
         sync_q  <= '0;
         last_q  <= '0;
         cnt     <= '0;
         o_clean <= '0;
      end else begin
         meta_q <= i_raw;
         sync_q <= meta_q;
         last_q <= sync_q;

         // Any change restarts the count, saturate once settled
         if (!stable) begin
            cnt <= '0;
         end else if (cnt != CNT_MAX) begin
            cnt <= cnt + 1'b1;
         end

         // CYCLES stable samples in a row
         if (stable && cnt == LOAD_AT) begin
            o_clean <= sync_q;
         end
      end
   end

endmodule

//--- hw/gpio_regs.sv
`include "periph_defines.svh"

module gpio_regs
   import wb_pkg::*;
#(
   parameter int WIDTH = `GPIO_W
) (
   input  logic             clk,
   input  logic             i_arst_n,
   wb_if.slave              s,
   input  logic [WIDTH-1:0] i_pad,
   output logic [WIDTH-1:0] o_out,
   output logic [WIDTH-1:0] o_oe,
   output logic             o_irq
);

   logic [WIDTH-1:0] pad_meta;
   logic [WIDTH-1:0] pad_sync;
   logic [WIDTH-1:0] pad_prev;
   logic [WIDTH-1:0] rise;
   logic [WIDTH-1:0] out_q;
   logic [WIDTH-1:0] oe_q;
   logic [WIDTH-1:0] irq_en_q;
   logic [WIDTH-1:0] irq_stat_q;
   logic [WIDTH-1:0] wr_bits;
   logic             req;
   logic             ack_q;
   logic             wr_en;
   reg_sel_e         rsel;

   assign req     = s.cyc & s.stb;
   // Write lands on the edge that raises ack
   assign wr_en   = req & s.we & ~ack_q;
   assign rsel    = reg_sel_e'(s.adr[`REG_MSB:`REG_LSB]);
   assign wr_bits = s.dat_w[WIDTH-1:0];
   assign rise    = pad_sync & ~pad_prev;

   // ********************
   // Pad synchronizer and edge detect
   // ********************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pad_meta <= '0;
         pad_sync <= '0;
         pad_prev <= '0;
      end else begin
         pad_meta <= i_pad;
         pad_sync <= pad_meta;
         pad_prev <= pad_sync;
      end
   end

   // ********************
   // Control registers
   // ********************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         out_q      <= '0;
         oe_q       <= '0;
         irq_en_q   <= '0;
         irq_stat_q <= '0;
      end else begin
         // Edges latch regardless of the enable
         irq_stat_q <= irq_stat_q | rise;
         if (wr_en) begin
            case (rsel)
               RS_OUT:      out_q    <= wr_bits;
               RS_OE:       oe_q     <= wr_bits;
               RS_IRQ_EN:   irq_en_q <= wr_bits;
               // A new edge wins over a clear in the same cycle
               RS_IRQ_STAT: irq_stat_q <= (irq_stat_q & ~wr_bits) | rise;
               default: ;
            endcase
         end
      end
   end

   // Single-cycle ack, never back to back
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req & ~ack_q;
      end
   end

   // Read path, zero-extended to the bus width
   always_comb begin
      case (rsel)
         RS_IN:       s.dat_r = wb_data_t'(pad_sync);
         RS_OUT:      s.dat_r = wb_data_t'(out_q);
         RS_OE:       s.dat_r = wb_data_t'(oe_q);
         RS_IRQ_EN:   s.dat_r = wb_data_t'(irq_en_q);
         RS_IRQ_STAT: s.dat_r = wb_data_t'(irq_stat_q);
         default:     s.dat_r = '0;
      endcase
   end

   assign s.ack = ack_q;
   assign o_out = out_q;
   assign o_oe  = oe_q;
   assign o_irq = |(irq_stat_q & irq_en_q);

endmodule

//--- hw/wb_decoder.sv
`include "periph_defines.svh"

module wb_decoder
   import wb_pkg::*;
(
   input  logic     clk,
   input  logic     i_arst_n,
   input  wb_addr_t i_wb_adr,
   input  wb_data_t i_wb_dat,
   input  logic     i_wb_we,
   input  logic     i_wb_cyc,
   input  logic     i_wb_stb,
   output wb_data_t o_wb_dat,
   output logic     o_wb_ack,
   wb_if.master     m_gpio,
   wb_if.master     m_btn,
   wb_if.master     m_bot,
   wb_if.master     m_bot_stat
);

   wb_slave_e sel;
   logic      req;
   logic      none_ack_q;

   assign req = i_wb_cyc & i_wb_stb;

   // Slave select from the top address nibble
   always_comb begin
      case (i_wb_adr[`SLV_MSB:`SLV_LSB])
         SLV_GPIO:     sel = SLV_GPIO;
         SLV_BTN:      sel = SLV_BTN;
         SLV_BOT:      sel = SLV_BOT;
         SLV_BOT_STAT: sel = SLV_BOT_STAT;
         default:      sel = SLV_NONE;
      endcase
   end

   // ********************
   // Request fan-out
   // ********************
   assign m_gpio.adr     = i_wb_adr;
   assign m_gpio.dat_w   = i_wb_dat;
   assign m_gpio.we      = i_wb_we;
   assign m_gpio.cyc     = i_wb_cyc & (sel == SLV_GPIO);
   assign m_gpio.stb     = i_wb_stb & (sel == SLV_GPIO);

   assign m_btn.adr      = i_wb_adr;
   assign m_btn.dat_w    = i_wb_dat;
   assign m_btn.we       = i_wb_we;
   assign m_btn.cyc      = i_wb_cyc & (sel == SLV_BTN);
   assign m_btn.stb      = i_wb_stb & (sel == SLV_BTN);

   assign m_bot.adr      = i_wb_adr;
   assign m_bot.dat_w    = i_wb_dat;
   assign m_bot.we       = i_wb_we;
   assign m_bot.cyc      = i_wb_cyc & (sel == SLV_BOT);
   assign m_bot.stb      = i_wb_stb & (sel == SLV_BOT);

   assign m_bot_stat.adr   = i_wb_adr;
   assign m_bot_stat.dat_w = i_wb_dat;
   assign m_bot_stat.we    = i_wb_we;
   assign m_bot_stat.cyc   = i_wb_cyc & (sel == SLV_BOT_STAT);
   assign m_bot_stat.stb   = i_wb_stb & (sel == SLV_BOT_STAT);

   // Unmapped space answers by itself, one-cycle pulse
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= req & (sel == SLV_NONE) & ~none_ack_q;
      end
   end

   // ********************
   // Response mux
   // ********************
   always_comb begin
      case (sel)
         SLV_GPIO: begin
            o_wb_dat = m_gpio.dat_r;
            o_wb_ack = m_gpio.ack;
         end
         SLV_BTN: begin
            o_wb_dat = m_btn.dat_r;
            o_wb_ack = m_btn.ack;
         end
         SLV_BOT: begin
            o_wb_dat = m_bot.dat_r;
            o_wb_ack = m_bot.ack;
         end
         SLV_BOT_STAT: begin
            o_wb_dat = m_bot_stat.dat_r;
            o_wb_ack = m_bot_stat.ack;
         end
         default: begin
            o_wb_dat = '0;
            o_wb_ack = none_ack_q;
         end
      endcase
   end

endmodule

//--- hw/periph_top.sv
`include "periph_defines.svh"

module periph_top
   import wb_pkg::*;
   import io_pkg::*;
(
   input  logic              clk,
   input  logic              i_arst_n,

   // Wishbone slave port
   input  wb_addr_t          i_wb_adr,
   input  wb_data_t          i_wb_dat,
   input  logic              i_wb_we,
   input  logic              i_wb_cyc,
   input  logic              i_wb_stb,
   output wb_data_t          o_wb_dat,
   output logic              o_wb_ack,

   // Board pads
   inout  wire [`GPIO_W-1:0] io_gpio,
   input  btn_t              i_btn,

   // Robot link
   input  bot_info_t         i_bot_info,
   input  logic              i_bot_updt_sync,
   output bot_ctrl_t         o_bot_ctrl,
   output logic              o_bot_config,

   output logic              o_irq
);

   logic [`GPIO_W-1:0] gpio_out;
   logic [`GPIO_W-1:0] gpio_oe;
   logic [`GPIO_W-1:0] bot_out;
   sw_t                sw_clean;
   btn_t               btn_clean;
   bot_stat_t          bot_stat;
   logic [3:0]         irq_vec;

   // ********************
   // Bus fabric
   // ********************
   wb_if bus_gpio ();
   wb_if bus_btn ();
   wb_if bus_bot ();
   wb_if bus_bot_stat ();

   wb_decoder u_decoder (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .i_wb_we    (i_wb_we),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .o_wb_dat   (o_wb_dat),
      .o_wb_ack   (o_wb_ack),
      .m_gpio     (bus_gpio),
      .m_btn      (bus_btn),
      .m_bot      (bus_bot),
      .m_bot_stat (bus_bot_stat)
   );

   // ********************
   // Debounce
   // ********************
   // Switches sit on the low GPIO pads
   debounce_filter #(
      .T (sw_t)
   ) u_sw_db (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_raw    (io_gpio[`SW_W-1:0]),
      .o_clean  (sw_clean)
   );

   debounce_filter #(
      .T (btn_t)
   ) u_btn_db (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_raw    (i_btn),
      .o_clean  (btn_clean)
   );

   assign o_bot_config = sw_clean[`SW_CFG_BIT];

   // ********************
   // Register blocks
   // ********************
   gpio_regs #(
      .WIDTH (`GPIO_W)
   ) u_gpio (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .s        (bus_gpio),
      .i_pad    (io_gpio),
      .o_out    (gpio_out),
      .o_oe     (gpio_oe),
      .o_irq    (irq_vec[0])
   );

   // Buttons are input only
   gpio_regs #(
      .WIDTH (`BTN_W)
   ) u_btn (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .s        (bus_btn),
      .i_pad    (btn_clean),
      .o_out    (),
      .o_oe     (),
      .o_irq    (irq_vec[1])
   );

   gpio_regs #(
      .WIDTH (`GPIO_W)
   ) u_bot (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .s        (bus_bot),
      .i_pad    (i_bot_info),
      .o_out    (bot_out),
      .o_oe     (),
      .o_irq    (irq_vec[2])
   );

   assign bot_stat.updt_sync = i_bot_updt_sync;
   assign bot_stat.cfg_sw    = o_bot_config;

   gpio_regs #(
      .WIDTH (`BOT_STAT_W)
   ) u_bot_stat (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .s        (bus_bot_stat),
      .i_pad    (bot_stat),
      .o_out    (),
      .o_oe     (),
      .o_irq    (irq_vec[3])
   );

   assign o_bot_ctrl = bot_ctrl_t'(bot_out[`BOT_CTRL_W-1:0]);
   assign o_irq      = |irq_vec;

   // Pad drivers, released where OE is clear
   for (genvar i = 0; i < `GPIO_W; i++) begin : g_pad
      assign io_gpio[i] = gpio_oe[i] ? gpio_out[i] : 1'bz;
   end

endmodule

//--- dv/periph_tests.svh
`ifndef PERIPH_TESTS_SVH
`define PERIPH_TESTS_SVH

// ********************
// Reset and board GPIO
// ********************
task automatic reset_values();
   int       err_start;
   wb_data_t rd;
   err_start = errors;
   check_eq("ack after reset", 32'(wb_ack), 32'h0);
   check_eq("irq after reset", 32'(irq), 32'h0);
   check_eq("bot_config after reset", 32'(bot_config), 32'h0);
   check_eq("bot_ctrl after reset", 32'(bot_ctrl), 32'h0);
   check_eq("io_gpio released after reset", io_gpio, 32'hzzzz_zzzz);
   for (int s = 0; s < 4; s++) begin
      wb_read(bus_addr(4'(s), RS_OUT), rd);
      check_eq("OUT after reset", rd, 32'h0);
      wb_read(bus_addr(4'(s), RS_OE), rd);
      check_eq("OE after reset", rd, 32'h0);
   end
   end_test("reset_values", err_start);
endtask

task automatic board_gpio();
   int       err_start;
   wb_data_t out_val;
   wb_data_t oe_val;
   wb_data_t pads;
   wb_data_t rd;
   err_start = errors;
   out_val   = $random(seed);
   oe_val    = $random(seed);
   wb_write(bus_addr(SLV_GPIO, RS_OUT), out_val);
   wb_write(bus_addr(SLV_GPIO, RS_OE), oe_val);
   // Board drives only the pads the DUT releases
   pads    = $random(seed);
   pad_drv = pads;
   pad_en  = ~oe_val;
   wait_cycles(3);
   check_eq("io_gpio on enabled bits", io_gpio & oe_val, out_val & oe_val);
   wb_read(bus_addr(SLV_GPIO, RS_IN), rd);
   check_eq("GPIO IN", rd, (out_val & oe_val) | (pads & ~oe_val));
   wb_read(bus_addr(SLV_GPIO, RS_OE), rd);
   check_eq("GPIO OE readback", rd, oe_val);
   end_test("board_gpio", err_start);
endtask

// ********************
// Buttons and robot port
// ********************
task automatic button_debounce();
   int       err_start;
   wb_data_t rd;
   err_start = errors;
   // Short bounce must be filtered out
   btn.centre = 1'b1;
   wait_cycles(DB / 2);
   btn.centre = 1'b0;
   wait_cycles(DB + 6);
   wb_read(bus_addr(SLV_BTN, RS_IN), rd);
   check_eq("BTN IN after short pulse", rd, 32'h0);
   wb_read(bus_addr(SLV_BTN, RS_IRQ_STAT), rd);
   check_eq("BTN IRQ_STAT after short pulse", rd, 32'h0);
   wb_write(bus_addr(SLV_BTN, RS_IRQ_EN), 32'h1f);
   btn.centre = 1'b1;
   wait_cycles(2 * DB);
   wb_read(bus_addr(SLV_BTN, RS_IN), rd);
   check_eq("BTN IN while held", rd, 32'h10);
   check_eq("irq on button press", 32'(irq), 32'h1);
   btn.centre = 1'b0;
   wait_cycles(DB + 6);
   wb_write(bus_addr(SLV_BTN, RS_IRQ_STAT), 32'h10);
   check_eq("irq after clear", 32'(irq), 32'h0);
   wb_read(bus_addr(SLV_BTN, RS_IRQ_STAT), rd);
   check_eq("BTN IRQ_STAT after clear", rd, 32'h0);
   wb_write(bus_addr(SLV_BTN, RS_IRQ_EN), 32'h0);
   end_test("button_debounce", err_start);
endtask

task automatic robot_link();
   int       err_start;
   wb_data_t val;
   wb_data_t rd;
   err_start = errors;
   val = $random(seed);
   wb_write(bus_addr(SLV_BOT, RS_OUT), val);
   check_eq("bot_ctrl", 32'(bot_ctrl), {24'h0, val[7:0]});
   val      = $random(seed);
   bot_info = val;
   wait_cycles(3);
   wb_read(bus_addr(SLV_BOT, RS_IN), rd);
   check_eq("BOT IN", rd, val);

   // Update sync edge with its enable set
   wb_write(bus_addr(SLV_BOT_STAT, RS_IRQ_EN), 32'h1);
   check_eq("irq before update sync", 32'(irq), 32'h0);
   bot_updt_sync = 1'b1;
   wait_cycles(4);
   check_eq("irq on update sync", 32'(irq), 32'h1);
   bot_updt_sync = 1'b0;
   wb_write(bus_addr(SLV_BOT_STAT, RS_IRQ_STAT), 32'h1);
   check_eq("irq after status clear", 32'(irq), 32'h0);

   // Drive every switch pad low before raising the config switch
   wb_write(bus_addr(SLV_GPIO, RS_OE), 32'h0);
   pad_en  = 32'h0000_ffff;
   pad_drv = 32'h0;
   wait_cycles(DB + 6);
   check_eq("bot_config with switch low", 32'(bot_config), 32'h0);
   pad_drv[`SW_CFG_BIT] = 1'b1;
   wait_cycles(DB / 2);
   check_eq("bot_config before debounce time", 32'(bot_config), 32'h0);
   wait_cycles(DB);
   check_eq("bot_config after debounce time", 32'(bot_config), 32'h1);
   wait_cycles(3);
   wb_read(bus_addr(SLV_BOT_STAT, RS_IN), rd);
   check_eq("BOT_STAT IN", rd, 32'h2);
   wb_read(bus_addr(SLV_BOT_STAT, RS_IRQ_STAT), rd);
   check_eq("BOT_STAT IRQ_STAT", rd, 32'h2);
   check_eq("irq with config edge not enabled", 32'(irq), 32'h0);
   end_test("robot_link", err_start);
endtask

// ********************
// Bus timing
// ********************
task automatic timed_access(input wb_addr_t addr, input logic we, input wb_data_t wdata,
                            input bit hold, output wb_data_t rdata);
   @(negedge clk);
   wb_adr   = addr;
   wb_dat_w = wdata;
   wb_we    = we;
   wb_cyc   = 1'b1;
   wb_stb   = 1'b1;
   @(negedge clk);
   check_eq("ack one cycle after request", 32'(wb_ack), 32'h1);
   rdata = wb_dat_r;
   if (hold) begin
      @(negedge clk);
      check_eq("ack of held request in next cycle", 32'(wb_ack), 32'h0);
      @(negedge clk);
      check_eq("ack of repeated request", 32'(wb_ack), 32'h1);
   end
   wb_cyc = 1'b0;
   wb_stb = 1'b0;
   wb_we  = 1'b0;
   @(negedge clk);
   check_eq("ack lasting one cycle", 32'(wb_ack), 32'h0);
endtask

task automatic bus_timing();
   int       err_start;
   wb_data_t rd;
   err_start = errors;
   timed_access(bus_addr(SLV_GPIO, RS_OUT), 1'b1, 32'h5a5a_00ff, 1'b1, rd);
   timed_access(bus_addr(SLV_GPIO, RS_OUT), 1'b0, 32'h0, 1'b0, rd);
   check_eq("GPIO OUT after timed write", rd, 32'h5a5a_00ff);
   timed_access(bus_addr(SLV_BTN, RS_IRQ_EN), 1'b0, 32'h0, 1'b0, rd);
   check_eq("BTN IRQ_EN after disable", rd, 32'h0);
   timed_access(bus_addr(SLV_BOT, RS_OE), 1'b0, 32'h0, 1'b0, rd);
   check_eq("BOT OE never written", rd, 32'h0);
   timed_access(bus_addr(SLV_BOT_STAT, RS_IN), 1'b0, 32'h0, 1'b0, rd);
   check_eq("BOT_STAT IN with config switch held", rd, 32'h2);
   // Unmapped slaves answer too
   timed_access(bus_addr(4'h7, RS_OUT), 1'b1, 32'hffff_ffff, 1'b1, rd);
   timed_access(bus_addr(4'h7, RS_OUT), 1'b0, 32'h0, 1'b0, rd);
   check_eq("unmapped read", rd, 32'h0);
   timed_access(bus_addr(4'hf, RS_IN), 1'b0, 32'h0, 1'b1, rd);
   check_eq("unmapped read, held", rd, 32'h0);
   end_test("bus_timing", err_start);
endtask

`endif

//--- dv/periph_tb.sv
`include "periph_defines.svh"

module periph_tb
   import wb_pkg::*;
   import io_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD      = 4;
   localparam int N_TESTS         = 5;
   localparam int CYCLES_PER_TEST = 400;
   localparam int ACK_LIMIT       = 10;
   localparam int DB              = `DB_CYCLES;

   logic               clk;
   logic               i_arst_n;
   wb_addr_t           wb_adr;
   wb_data_t           wb_dat_w;
   logic               wb_we;
   logic               wb_cyc;
   logic               wb_stb;
   wb_data_t           wb_dat_r;
   logic               wb_ack;
   wire [`GPIO_W-1:0]  io_gpio;
   btn_t               btn;
   bot_info_t          bot_info;
   logic               bot_updt_sync;
   bot_ctrl_t          bot_ctrl;
   logic               bot_config;
   logic               irq;

   // Board side of the pads
   logic [`GPIO_W-1:0] pad_drv;
   logic [`GPIO_W-1:0] pad_en;

   int errors;
   int tests_ok;
   int tests_bad;
   integer seed;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   for (genvar i = 0; i < `GPIO_W; i++) begin : g_pad_drv
      assign io_gpio[i] = pad_en[i] ? pad_drv[i] : 1'bz;
   end

   periph_top dut_i (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_wb_adr        (wb_adr),
      .i_wb_dat        (wb_dat_w),
      .i_wb_we         (wb_we),
      .i_wb_cyc        (wb_cyc),
      .i_wb_stb        (wb_stb),
      .o_wb_dat        (wb_dat_r),
      .o_wb_ack        (wb_ack),
      .io_gpio         (io_gpio),
      .i_btn           (btn),
      .i_bot_info      (bot_info),
      .i_bot_updt_sync (bot_updt_sync),
      .o_bot_ctrl      (bot_ctrl),
      .o_bot_config    (bot_config),
      .o_irq           (irq)
   );

   // ********************
   // Helpers
   // ********************
   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   function automatic wb_addr_t bus_addr(input logic [3:0] slv, input reg_sel_e rsel);
      wb_addr_t a;
      a = '0;
      a[`SLV_MSB:`SLV_LSB] = slv;
      a[`REG_MSB:`REG_LSB] = rsel;
      return a;
   endfunction

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Request on a falling edge, hold until ack, then release
   task automatic bus_cycle(input wb_addr_t addr, input logic we, input wb_data_t wdata,
                            output wb_data_t rdata);
      int waited;
      @(negedge clk);
      wb_adr   = addr;
      wb_dat_w = wdata;
      wb_we    = we;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      waited   = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (wb_ack !== 1'b1 && waited < ACK_LIMIT);
      assert (wb_ack === 1'b1) else begin
         $display("no acknowledge within %0d cycles for address %h", ACK_LIMIT, addr);
         errors++;
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
      wb_data_t unused;
      bus_cycle(addr, 1'b1, data, unused);
   endtask

   task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
      bus_cycle(addr, 1'b0, '0, data);
   endtask

   task automatic end_test(input string name, input int err_start);
      if (errors == err_start) begin
         tests_ok++;
         $display("%-16s ok", name);
      end else begin
         tests_bad++;
         $display("%-16s FAIL, %0d errors", name, errors - err_start);
      end
   endtask

   `include "periph_tests.svh"

   // Watchdog sized from the test count
   initial begin
      #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("Test failed");
      $finish;
   end

   initial begin
      seed          = 12;
      errors        = 0;
      tests_ok      = 0;
      tests_bad     = 0;
      i_arst_n      = 1'b0;
      wb_adr        = '0;
      wb_dat_w      = '0;
      wb_we         = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      btn           = '0;
      bot_info      = '0;
      bot_updt_sync = 1'b0;
      pad_drv       = '0;
      pad_en        = '0;
      repeat (8) @(negedge clk);
      i_arst_n = 1'b1;

      reset_values();
      board_gpio();
      button_debounce();
      robot_link();
      bus_timing();

      $display("summary: %0d tests ok, %0d tests failing, %0d errors",
               tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- sources.f
+incdir+hw
+incdir+dv
hw/wb_pkg.sv
hw/io_pkg.sv
hw/wb_if.sv
hw/debounce_filter.sv
hw/gpio_regs.sv
hw/wb_decoder.sv
hw/periph_top.sv
dv/periph_tb.sv
